// File: logic/addr_result.sv
`default_nettype none
`timescale 1ns/1ps
`include "fish_config.svh"

module addr_result
    import fish_pkg::*;
(
    input  wire                clk,
    input  wire                arst_n,
    input  wire warp_t         warp_x,
    input  wire warp_t         warp_y,
    output logic [`ADDR_W-1:0] addr
);

    coord_t wx;                       // window relative x
    coord_t wy;                       // window relative y
    logic   x_in;
    logic   y_in;
    logic [`ADDR_W-1:0] lin_addr;     // word address before the halving

    // both bounds exclusive, 0 counts as outside
    assign x_in = (wx > 0) && (wx < `WIN_X_LIMIT);
    assign y_in = (wy > 0) && (wy < `WIN_Y_LIMIT);

    assign lin_addr = `ADDR_W'(`ROW_PITCH * wy + wx);   // wraps at 17 bits

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wx   <= '0;
            wy   <= '0;
            addr <= '0;
        end
        else
        begin
            wx <= warp_x[10:0] - `WIN_OFFSET;
            wy <= warp_y[10:0] - `WIN_OFFSET;
            if (x_in && y_in)
                addr <= lin_addr >> 1;    // two pixels per buffer word
            else
                addr <= '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/fish_config.svh
`ifndef FISH_CONFIG_SVH
`define FISH_CONFIG_SVH

// raster counter offsets
`define H_VBI           11'sd0
`define V_VBI           11'sd0

// homography coefficients, 20 bit signed
`define ROT_A           20'sd44664
`define ROT_B           20'sd46245
`define ROT_D           20'sd4040
`define ROT_E           20'sd79016
`define ROT_G           20'sd15
`define ROT_H           20'sd154

// translation terms, 12 bit signed
`define ROT_C           (-12'sd458)
`define ROT_F           (-12'sd334)

// reciprocal divider
`define DIV_NUMER_SHIFT 29                  // dividend is 2^29
`define DIV_Q_BITS      30                  // one quotient bit per stage
`define DIV_LATENCY     (`DIV_Q_BITS + 2)   // entry + stages + exit

// output window
`define WIN_OFFSET      11'sd80
`define WIN_X_LIMIT     481                 // exclusive
`define WIN_Y_LIMIT     321                 // exclusive

// frame buffer
`define ROW_PITCH       480                 // words per row
`define ADDR_W          17

`endif

// File: logic/fish_pkg.sv
`default_nettype none

package fish_pkg;

    // raster or window coordinate
    typedef logic signed [10:0] coord_t;

    // truncated coefficient term c1..c4
    typedef logic signed [20:0] coef_t;

    // warp numerator, bits 29:9 of the full product difference
    typedef logic signed [20:0] num_t;

    // scaled reciprocal of the denominator
    typedef logic signed [19:0] recip_t;

    // warped coordinate, integer pixels
    typedef logic signed [12:0] warp_t;

endpackage

`default_nettype wire

// File: logic/fish_remap.sv
`default_nettype none
`timescale 1ns/1ps
`include "fish_config.svh"

module fish_remap
    import fish_pkg::*;
(
    input  wire                clk,
    input  wire                arst_n,
    input  wire coord_t        x_cnt,
    input  wire coord_t        y_cnt,
    output logic [`ADDR_W-1:0] addr
);

    logic signed [41:0] denom;    // 4 cycles after input
    num_t               num_x;
    num_t               num_y;
    warp_t              warp_x;   // 38 cycles after input
    warp_t              warp_y;

    homo_decode u_decode
    (
        .clk    (clk),
        .arst_n (arst_n),
        .x_cnt  (x_cnt),
        .y_cnt  (y_cnt),
        .denom  (denom),
        .num_x  (num_x),
        .num_y  (num_y)
    );

    homo_execute u_execute
    (
        .clk    (clk),
        .arst_n (arst_n),
        .denom  (denom),
        .num_x  (num_x),
        .num_y  (num_y),
        .warp_x (warp_x),
        .warp_y (warp_y)
    );

    // address out 40 cycles after input
    addr_result u_result
    (
        .clk    (clk),
        .arst_n (arst_n),
        .warp_x (warp_x),
        .warp_y (warp_y),
        .addr   (addr)
    );

endmodule

`default_nettype wire

// File: logic/homo_decode.sv
`default_nettype none
`timescale 1ns/1ps
`include "fish_config.svh"

module homo_decode
    import fish_pkg::*;
(
    input  wire                clk,
    input  wire                arst_n,
    input  wire coord_t        x_cnt,
    input  wire coord_t        y_cnt,
    output logic signed [41:0] denom,
    output num_t               num_x,
    output num_t               num_y
);

    coord_t p;                     // pixel after vbi offset
    coord_t l;                     // line after vbi offset

    logic signed [30:0] gp;        // G*p
    logic signed [30:0] hl;        // H*l
    logic signed [30:0] hp;        // H*p
    logic signed [30:0] gl;        // G*l

    coef_t c1;
    coef_t c2;
    coef_t c3;
    coef_t c4;

    logic signed [41:0] c1c2;
    logic signed [41:0] c3c4;

    logic signed [11:0] x0_pre;    // p - C, first cycle
    logic signed [11:0] x1_pre;    // l - F, first cycle
    logic signed [11:0] x0;        // lined up with c1..c4
    logic signed [11:0] x1;

    logic signed [34:0] c2x0;
    logic signed [34:0] c3x1;
    logic signed [34:0] c1x1;
    logic signed [34:0] c4x0;
    logic signed [34:0] nx_full;
    logic signed [34:0] ny_full;

    assign p = x_cnt - `H_VBI;
    assign l = y_cnt - `V_VBI;

    // denominator path
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            gp    <= '0;
            hl    <= '0;
            hp    <= '0;
            gl    <= '0;
            c1    <= '0;
            c2    <= '0;
            c3    <= '0;
            c4    <= '0;
            c1c2  <= '0;
            c3c4  <= '0;
            denom <= '0;
        end
        else
        begin
            gp    <= `ROT_G * p;              // stage 1
            hl    <= `ROT_H * l;
            hp    <= `ROT_H * p;
            gl    <= `ROT_G * l;
            c1    <= coef_t'(`ROT_A - gp);    // stage 2, low 21 bits kept
            c2    <= coef_t'(`ROT_E - hl);
            c3    <= coef_t'(`ROT_B - hp);
            c4    <= coef_t'(`ROT_D - gl);
            c1c2  <= c1 * c2;                 // stage 3
            c3c4  <= c3 * c4;
            denom <= c1c2 - c3c4;             // stage 4
        end
    end

    // numerator path, runs beside the denominator
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            x0_pre  <= '0;
            x1_pre  <= '0;
            x0      <= '0;
            x1      <= '0;
            c2x0    <= '0;
            c3x1    <= '0;
            c1x1    <= '0;
            c4x0    <= '0;
            nx_full <= '0;
            ny_full <= '0;
        end
        else
        begin
            x0_pre  <= p - `ROT_C;
            x1_pre  <= l - `ROT_F;
            x0      <= x0_pre;               // wait for c1..c4
            x1      <= x1_pre;
            c2x0    <= c2 * x0;
            c3x1    <= c3 * x1;
            c1x1    <= c1 * x1;
            c4x0    <= c4 * x0;
            nx_full <= c2x0 - c3x1;
            ny_full <= c1x1 - c4x0;
        end
    end

    // drop 9 fraction bits
    assign num_x = nx_full[29:9];
    assign num_y = ny_full[29:9];

endmodule

`default_nettype wire

// File: logic/homo_execute.sv
`default_nettype none
`timescale 1ns/1ps
`include "fish_config.svh"

module homo_execute
    import fish_pkg::*;
(
    input  wire                clk,
    input  wire                arst_n,
    input  wire signed [41:0]  denom,
    input  wire num_t          num_x,
    input  wire num_t          num_y,
    output warp_t              warp_x,
    output warp_t              warp_y
);

    logic signed [15:0]             divisor;
    logic signed [`DIV_Q_BITS-1:0] quotient;
    recip_t                         recip;

    num_t nx_dly [0:`DIV_LATENCY-1];    // numerators wait for the divider
    num_t ny_dly [0:`DIV_LATENCY-1];

    logic signed [40:0] prod_x;
    logic signed [40:0] prod_y;

    assign divisor = denom[33:18];       // denominator scaled down by 2^18

    recip_divider u_div
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .divisor  (divisor),
        .quotient (quotient)
    );

    assign recip = quotient[28:9];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `DIV_LATENCY; i++)
            begin
                nx_dly[i] <= '0;
                ny_dly[i] <= '0;
            end
        end
        else
        begin
            nx_dly[0] <= num_x;
            ny_dly[0] <= num_y;
            for (int i = 1; i < `DIV_LATENCY; i++)
            begin
                nx_dly[i] <= nx_dly[i-1];
                ny_dly[i] <= ny_dly[i-1];
            end
        end
    end

    // scale by the reciprocal, then keep the integer part
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            prod_x <= '0;
            prod_y <= '0;
            warp_x <= '0;
            warp_y <= '0;
        end
        else
        begin
            prod_x <= nx_dly[`DIV_LATENCY-1] * recip;   // same pixel as recip
            prod_y <= ny_dly[`DIV_LATENCY-1] * recip;
            warp_x <= prod_x[27:15];
            warp_y <= prod_y[27:15];
        end
    end

endmodule

`default_nettype wire

// File: logic/recip_divider.sv
`default_nettype none
`timescale 1ns/1ps
`include "fish_config.svh"

module recip_divider
(
    input  wire                            clk,
    input  wire                            arst_n,
    input  wire signed [15:0]              divisor,
    output logic signed [`DIV_Q_BITS-1:0] quotient
);

    localparam int QB = `DIV_Q_BITS;

    // index 0 is the entry stage
    logic [15:0]   mag_q [0:QB];     // divisor magnitude travels along
    logic          neg_q [0:QB];     // result sign
    logic [15:0]   rem_q [1:QB-1];   // partial remainder below mag
    logic [QB-1:0] quo_q [1:QB];     // quotient bits shifted in msb first

    logic [16:0]   step  [1:QB];     // {quotient bit, next remainder}

    // one restoring step
    function automatic logic [16:0] div_step(
        input logic [15:0] rem,
        input logic        numer_bit,
        input logic [15:0] mag
    );
        logic [16:0] trial;
        logic [16:0] diff;
        trial = {rem, numer_bit};
        diff  = trial - {1'b0, mag};
        if (trial >= {1'b0, mag})
            return {1'b1, diff[15:0]};
        return {1'b0, trial[15:0]};
    endfunction

    // dividend is a single one at bit DIV_NUMER_SHIFT
    always_comb
    begin
        step[1] = div_step(16'd0, (QB - 1) == `DIV_NUMER_SHIFT, mag_q[0]);   // empty remainder
        for (int i = 2; i <= QB; i++)
            step[i] = div_step(rem_q[i-1], (QB - i) == `DIV_NUMER_SHIFT, mag_q[i-1]);
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i <= QB; i++)
            begin
                mag_q[i] <= '0;
                neg_q[i] <= 1'b0;
            end
            for (int i = 1; i < QB; i++)
                rem_q[i] <= '0;
            for (int i = 1; i <= QB; i++)
                quo_q[i] <= '0;
            quotient <= '0;
        end
        else
        begin
            mag_q[0] <= divisor[15] ? 16'(-divisor) : 16'(divisor);   // -32768 maps to 0x8000
            neg_q[0] <= divisor[15];
            for (int i = 1; i <= QB; i++)
            begin
                mag_q[i] <= mag_q[i-1];
                neg_q[i] <= neg_q[i-1];
            end
            for (int i = 1; i < QB; i++)
                rem_q[i] <= step[i][15:0];
            quo_q[1] <= {{(QB-1){1'b0}}, step[1][16]};
            for (int i = 2; i <= QB; i++)
                quo_q[i] <= {quo_q[i-1][QB-2:0], step[i][16]};
            // exit stage puts the sign back
            if (mag_q[QB] == '0)
                quotient <= '0;                   // zero divisor gives 0
            else if (neg_q[QB])
                quotient <= -$signed(quo_q[QB]);
            else
                quotient <= $signed(quo_q[QB]);
        end
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
+incdir+test
logic/fish_pkg.sv
logic/recip_divider.sv
logic/homo_decode.sv
logic/homo_execute.sv
logic/addr_result.sv
logic/fish_remap.sv
test/fish_remap_tb.sv

// File: test/fish_remap_model.svh
`ifndef FISH_REMAP_MODEL_SVH
`define FISH_REMAP_MODEL_SVH

// sign extend the low n bits of v
function automatic longint sext(input longint v, input int n);
    longint one;
    longint m;
    one = 1;
    m = v & ((one << n) - 1);
    if (m >= (one << (n - 1)))
        m = m - (one << n);           // top bit set, so negative
    return m;
endfunction

// bits hi..lo of v read as a signed field
function automatic longint field(input longint v, input int hi, input int lo);
    return sext(v >>> lo, hi - lo + 1);
endfunction

// expected read address for one raster coordinate
function automatic logic [`ADDR_W-1:0] ref_addr(
    input  int x,
    input  int y,
    output bit in_win
);
    longint p;
    longint l;
    longint c1;
    longint c2;
    longint c3;
    longint c4;
    longint den;
    longint x0;
    longint x1;
    longint nx;
    longint ny;
    longint dv;
    longint mag;
    longint q;
    longint rcp;
    longint wx;
    longint wy;
    longint lin;
    p  = sext(x - `H_VBI, 11);
    l  = sext(y - `V_VBI, 11);
    // coefficient terms, 21 bits each
    c1 = sext(`ROT_A - `ROT_G * p, 21);
    c2 = sext(`ROT_E - `ROT_H * l, 21);
    c3 = sext(`ROT_B - `ROT_H * p, 21);
    c4 = sext(`ROT_D - `ROT_G * l, 21);
    den = sext(c1 * c2 - c3 * c4, 42);
    x0 = sext(p - `ROT_C, 12);            // translated pixel
    x1 = sext(l - `ROT_F, 12);            // translated line
    nx = field(c2 * x0 - c3 * x1, 29, 9);
    ny = field(c1 * x1 - c4 * x0, 29, 9);
    // reciprocal, truncated toward zero
    dv  = field(den, 33, 18);
    mag = (dv < 0) ? -dv : dv;
    if (mag == 0)
        q = 0;                            // zero divisor gives zero
    else
        q = (longint'(1) << `DIV_NUMER_SHIFT) / mag;
    if (dv < 0)
        q = -q;
    rcp = field(q, 28, 9);
    // warp, then window offset on the low 11 bits
    wx = sext(field(nx * rcp, 27, 15) - `WIN_OFFSET, 11);
    wy = sext(field(ny * rcp, 27, 15) - `WIN_OFFSET, 11);
    in_win = (wx > 0) && (wx < `WIN_X_LIMIT) && (wy > 0) && (wy < `WIN_Y_LIMIT);
    if (!in_win)
        return '0;
    lin = (`ROW_PITCH * wy + wx) & ((longint'(1) << `ADDR_W) - 1);   // wraps at 17 bits
    return `ADDR_W'(lin >> 1);
endfunction

// 32 bit linear congruential step
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

`endif

// File: test/fish_remap_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "fish_config.svh"

module fish_remap_tb
    import fish_pkg::*;
();

    localparam int LATENCY     = 40;   // input edge to addr
    localparam int DRAIN_LIMIT = 100;

    logic               clk = 1'b0;
    logic               arst_n;
    coord_t             x_cnt;
    coord_t             y_cnt;
    logic [`ADDR_W-1:0] addr;

    int    qx[$];          // coordinates in flight oldest first
    int    qy[$];
    string qname[$];
    int    pushed;
    int    popped;
    int    n_inside;       // checked outputs inside the window
    int    n_outside;
    logic [31:0] seed;

    `include "fish_remap_model.svh"

    fish_remap fish_remap_i
    (
        .clk    (clk),
        .arst_n (arst_n),
        .x_cnt  (x_cnt),
        .y_cnt  (y_cnt),
        .addr   (addr)
    );

    always #10 clk = ~clk;     // 20 ns period

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // drive one coordinate, then move to 1 ns after the next edge
    task automatic apply_pixel(input int x, input int y, input string name);
        x_cnt = coord_t'(x);
        y_cnt = coord_t'(y);
        qx.push_back(x);
        qy.push_back(y);
        qname.push_back(name);
        pushed++;
        @(posedge clk);
        #1;
    endtask

    // pixels in flight are lost on reset
    task automatic reset_pipeline(input int cycles);
        arst_n = 1'b0;
        pushed = pushed - qx.size();
        qx.delete();
        qy.delete();
        qname.delete();
        repeat (cycles)
        begin
            @(posedge clk);
            #1;
        end
        arst_n = 1'b1;
    endtask

    // outputs are read mid cycle
    always @(negedge clk)
    begin : compare
        int                 cx;
        int                 cy;
        string              cn;
        logic [`ADDR_W-1:0] exp_addr;
        bit                 in_win;
        if (!arst_n)
        begin
            assert (addr == '0)
            else fail_run($sformatf("addr is %0d while reset is asserted", addr));
        end
        else if (qx.size() > LATENCY)
        begin
            cx = qx.pop_front();
            cy = qy.pop_front();
            cn = qname.pop_front();
            popped++;
            exp_addr = ref_addr(cx, cy, in_win);
            if (in_win)
                n_inside++;
            else
                n_outside++;
            assert (addr == exp_addr)
            else fail_run($sformatf("MISMATCH %s x=%0d y=%0d expected %0d actual %0d",
                                    cn, cx, cy, exp_addr, addr));
        end
        else
        begin
            // pipeline still holds cleared values
            assert (addr == '0)
            else fail_run($sformatf("addr is %0d before the first result is due", addr));
        end
    end

    initial
    begin
        int rx;
        int ry;
        int target;
        int waited;
        arst_n    = 1'b0;
        x_cnt     = '0;
        y_cnt     = '0;
        pushed    = 0;
        popped    = 0;
        n_inside  = 0;
        n_outside = 0;
        seed      = 32'h9b0405a2;
        reset_pipeline(5);

        // corners, centre, origin
        apply_pixel(0, 0, "directed");
        apply_pixel(639, 0, "directed");
        apply_pixel(0, 479, "directed");
        apply_pixel(639, 479, "directed");
        apply_pixel(320, 240, "directed");
        apply_pixel(0, 0, "directed");

        for (int i = 0; i < 640; i++)
            apply_pixel(i, 240, "row_sweep");    // one per clock

        for (int i = 0; i < 300; i++)
        begin
            seed = lcg_next(seed);
            rx   = int'(seed[31:16] % 640);
            seed = lcg_next(seed);
            ry   = int'(seed[31:16] % 480);
            apply_pixel(rx, ry, "random");
        end

        reset_pipeline(5);                       // mid stream

        for (int i = 0; i < 300; i++)
        begin
            seed = lcg_next(seed);
            rx   = int'(seed[31:16] % 640);
            seed = lcg_next(seed);
            ry   = int'(seed[31:16] % 480);
            apply_pixel(rx, ry, "after_reset");
        end

        // keep feeding until the last real pixel is checked
        target = pushed;
        waited = 0;
        while (popped < target)
        begin
            if (waited >= DRAIN_LIMIT)
                fail_run("timeout: results for the last coordinates never arrived");
            else
            begin
                apply_pixel(0, 0, "drain");
                waited++;
            end
        end

        assert (n_outside > 0)
        else fail_run("no checked output fell outside the window");
        assert (n_inside > 0)
        else fail_run("no checked output fell inside the window");

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
